/* compile.f */
+incdir+.
starkDecodePkg.sv
regMapper.sv
destDecoder.sv
srcDecoder.sv
decodeStage.sv
decodeTop.sv
decodeTb.sv

/* run.sh */
#!/bin/sh
# Build the decode testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module decodeTb -f compile.f &&
./obj_dir/VdecodeTb | tee /dev/stderr | grep -x "TEST RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* decodeTbRef.svh */
// Expected decoded record for one instruction and mode, included inside the testbench module
`ifndef DECODE_TB_REF_SVH
`define DECODE_TB_REF_SVH

// Stack pointer banking and legality of one register number
function automatic aregno_t mapBanked(input aregno_t r, input operating_mode_t m,
	input logic bank, output logic e);
	e = (r > 7'd71) || (bank && m == MODE_USER && r >= 7'd64 && r <= 7'd71);
	return (r == 7'd31) ? aregno_t'(7'd120 + m) : r;
endfunction

function automatic decoded_t predictRecord(input instruction_t w, input operating_mode_t m);
	decoded_t res;
	aregno_t  d;
	aregno_t  s1;
	aregno_t  s2;
	logic     e1;
	logic     e2;
	logic     e3;
	logic     alu;
	logic     ld;
	logic     br;
	logic     mov;
	alu = w.opcode inside {OP_ADD, OP_SUBF, OP_CMP, OP_AND, OP_OR, OP_XOR, OP_MUL,
		OP_DIV, OP_SHIFT};
	ld  = w.opcode inside {OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD,
		OP_LOADA, OP_AMO, OP_CMPSWAP};
	br  = w.opcode inside {OP_B0, OP_B1, OP_BCC0, OP_BCC1};
	mov = (w.opcode == OP_MOV);
	d  = (alu || ld || w.opcode == OP_CSR || mov) ? 7'(w.rd) : 7'd0;
	if (w.opcode == OP_FLT)
		d = 7'd32 + 7'(w.rd);
	if (mov && w[28:26] < 3'd4)
		d = {w[18:17], w.rd};
	if (br)
		d = (w[8:6] == 3'd0 || w[8:6] == 3'd7) ? 7'd0 : 7'd64 + 7'(w[8:6]);
	s1 = (alu || ld || br || mov || w.opcode inside {OP_CSR, OP_STORE}) ? 7'(w.rs1) : 7'd0;
	if (w.opcode == OP_FLT)
		s1 = 7'd32 + 7'(w.rs1);
	if (mov && w[28:26] >= 3'd4)
		s1 = {w[20:19], w.rs1};
	s2 = ((alu && !w[31]) || w.opcode inside {OP_STORE, OP_CMPSWAP}) ? 7'(w.rs2) : 7'd0;
	if (w.opcode == OP_FLT)
		s2 = 7'd32 + 7'(w.rs2);
	res.instr = w;
	res.mode  = (mov && w[28:26] == 3'd1) ? operating_mode_t'(w[22:21]) : m;
	res.rd    = mapBanked(d, res.mode, mov && w[28:26] < 3'd4, e1);
	res.rdz   = (res.rd == 7'd0);
	res.rs1   = mapBanked(s1, m, mov && w[28:26] >= 3'd4, e2);
	res.rs2   = mapBanked(s2, m, 1'b0, e3);
	res.exc   = e1 | e2 | e3;
	return res;
endfunction

`endif

/* decodeTb.sv */
// Simulation top that drives decodeTop through every decode behavior and checks each returned record
`timescale 1ns/100ps
`default_nettype none

module decodeTb import starkDecodePkg::*; ();

	localparam int RecordsPerTest = 40;
	localparam int NumTests       = 6;
	// Twenty cycles per record plus a margin for reset and draining
	localparam int WatchdogCycles = NumTests * RecordsPerTest * 20 + 200;

	logic      clk = 1'b0;
	logic      arstN = 1'b0;
	logic      inValid = 1'b0;
	logic      inReady;
	decodeIn_t inData = '0;
	logic      outValid;
	decoded_t  outData;
	logic      outReady = 1'b1;

	int seed = 32'h4254;
	int stallSeed = 32'h4254;
	int passCount = 0;
	int failCount = 0;
	int cycle = 0;
	int acceptCount = 0;
	int outCount = 0;
	logic stallOutput = 1'b0;
	logic latencyTest = 1'b0;
	decoded_t expQ[$];
	int acceptQ[$];

	// Every opcode the decoders know, plus one no-register code
	opcode_t allOps [28] = '{OP_NOP, OP_ADD, OP_SUBF, OP_CMP, OP_AND, OP_OR, OP_XOR,
		OP_MUL, OP_DIV, OP_SHIFT, OP_FLT, OP_CSR, OP_MOV, OP_B0, OP_B1, OP_BCC0, OP_BCC1,
		OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD, OP_LOADA, OP_AMO,
		OP_CMPSWAP, OP_STORE};
	opcode_t srcOps [6] = '{OP_ADD, OP_XOR, OP_FLT, OP_STORE, OP_CMPSWAP, OP_CSR};

	`include "decodeTbRef.svh"

	decodeTop UUT (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.outValid (outValid),
		.outData  (outData),
		.outReady (outReady)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Checking helpers
	// ==================================================

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			failCount++;
		end
		else
			passCount++;
	endtask

	// Transfers are judged on the values present at the rising edge
	always @(posedge clk)
	begin
		decoded_t exp;
		int acceptedAt;
		if (arstN)
		begin
			cycle++;
			if (outValid && outReady)
			begin
				outCount++;
				if (expQ.size() == 0)
				begin
					$display("Error at %0t ns: a record came out that was never sent", $time);
					failCount++;
				end
				else
				begin
					exp = expQ.pop_front();
					acceptedAt = acceptQ.pop_front();
					checkValue("outData.instr", exp.instr, outData.instr);
					checkValue("outData.mode", exp.mode, outData.mode);
					checkValue("outData.rd", exp.rd, outData.rd);
					checkValue("outData.rdz", exp.rdz, outData.rdz);
					checkValue("outData.rs1", exp.rs1, outData.rs1);
					checkValue("outData.rs2", exp.rs2, outData.rs2);
					checkValue("outData.exc", exp.exc, outData.exc);
					if (latencyTest)
						checkValue("latency", 64'd1, 64'(cycle - acceptedAt));
				end
			end
			if (!outValid && !inReady)
			begin
				$display("Error at %0t ns: inReady is low with an empty output slot", $time);
				failCount++;
			end
			// With the consumer always ready a new word must go in every cycle
			if (latencyTest && inValid)
				checkValue("inReady", 64'd1, 64'(inReady));
			if (inValid && inReady)
			begin
				expQ.push_back(predictRecord(inData.instr, inData.mode));
				acceptQ.push_back(cycle);
				acceptCount++;
			end
		end
	end

	// The consumer stalls at random about one cycle in four
	always @(posedge clk)
	begin
		logic [31:0] rnd;
		#1;
		rnd = $random(stallSeed);
		outReady = stallOutput ? (rnd[1:0] != 2'd0) : 1'b1;
	end

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic makeInput(input int kind, input int idx, output decodeIn_t d);
		instruction_t    w;
		operating_mode_t m;
		logic [31:0]     rnd;
		w = $random(seed);
		rnd = $random(seed);
		m = operating_mode_t'(rnd[1:0]);
		case (kind)
			1: w.opcode = allOps[idx % 28];
			2:
			begin
				// Walk all modes and use the stack pointer on every other word
				w.opcode = srcOps[idx % 6];
				m = operating_mode_t'(idx[2:1]);
				if (!idx[0])
				begin
					w.rs1 = 5'd31;
					w.rs2 = 5'd31;
				end
			end
			3:
			begin
				w.opcode = OP_MOV;
				w[28:26] = 3'd1;
				w.rs1 = 5'd31;
				if (!idx[0])
				begin
					w[18:17] = 2'd0;
					w.rd = 5'd31;
				end
			end
			4:
			begin
				if (idx[0])
					w.opcode = allOps[idx % 28];
				else
					w.opcode = OP_MOV;
				// User mode write into the link registers through bank 2
				if (idx % 4 == 0)
				begin
					w[28:26] = 3'd0;
					w[18:17] = 2'd2;
					w.rd[4:3] = 2'd0;
					m = MODE_USER;
				end
			end
			default: w.opcode = allOps[rnd[31:2] % 28];
		endcase
		d.instr = w;
		d.mode = m;
	endtask

	// Holds the word on the input until the monitor has seen it accepted
	task automatic sendOne(input decodeIn_t d);
		int target;
		target = acceptCount + 1;
		inValid = 1'b1;
		inData = d;
		while (acceptCount < target)
		begin
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;
	endtask

	task automatic runTest(input string name, input int kind, input logic stall);
		decodeIn_t d;
		int        i;
		int        failsBefore;
		int        outBefore;
		failsBefore = failCount;
		outBefore = outCount;
		stallOutput = stall;
		latencyTest = (kind == 6);
		repeat (2)
		begin
			@(posedge clk);
			#1;
		end
		for (i = 0; i < RecordsPerTest; i++)
		begin
			makeInput(kind, i, d);
			sendOne(d);
		end
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
		checkValue("records out", 64'(RecordsPerTest), 64'(outCount - outBefore));
		latencyTest = 1'b0;
		$display("Test %0d %s: %0d records, %0d failures", kind, name, RecordsPerTest,
			failCount - failsBefore);
	endtask

	initial
	begin
		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;
		// Empty slot after reset
		checkValue("outValid", 64'd0, 64'(outValid));
		checkValue("inReady", 64'd1, 64'(inReady));
		runTest("destination selection", 1, 1'b0);
		runTest("source selection and mapping", 2, 1'b0);
		runTest("mode move", 3, 1'b0);
		runTest("exceptions", 4, 1'b0);
		runTest("back-pressure", 5, 1'b1);
		runTest("latency and throughput", 6, 1'b0);
		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * 100);
		$display("Watchdog expired before all records came back");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* decodeTop.sv */
// Top of the decode slice, connecting both register decoders to the output stage
`timescale 1ns/100ps
`default_nettype none

module decodeTop import starkDecodePkg::*; (
	input wire logic      clk,
	input wire logic      arstN,
	input wire logic      inValid,
	output logic          inReady,
	input wire decodeIn_t inData,
	output logic          outValid,
	output decoded_t      outData,
	input wire logic      outReady
);

	destInfo_t destRes;
	srcInfo_t  srcRes;

	// Both decoders look at the same input word in parallel
	destDecoder destDec (
		.inData (inData),
		.dest   (destRes)
	);

	srcDecoder srcDec (
		.inData (inData),
		.src    (srcRes)
	);

	decodeStage stage (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.dest     (destRes),
		.src      (srcRes),
		.outValid (outValid),
		.outData  (outData),
		.outReady (outReady)
	);

endmodule

`default_nettype wire

/* decodeStage.sv */
// Merges destination and source results into the decoded record and registers it with valid/ready
`timescale 1ns/100ps
`default_nettype none

module decodeStage import starkDecodePkg::*; (
	input wire logic      clk,
	input wire logic      arstN,
	input wire logic      inValid,
	output logic          inReady,
	input wire decodeIn_t inData,
	input wire destInfo_t dest,
	input wire srcInfo_t  src,
	output logic          outValid,
	output decoded_t      outData,
	input wire logic      outReady
);

	decoded_t nextRec;
	logic     inFire;

	// ==================================================
	// Record assembly
	// ==================================================

	always_comb
	begin
		nextRec.instr = inData.instr;
		// The mode after a possible mode move travels with the record
		nextRec.mode  = dest.mode;
		nextRec.rd    = dest.rd;
		nextRec.rdz   = dest.rdz;
		nextRec.rs1   = src.rs1;
		nextRec.rs2   = src.rs2;
		// One flag is enough downstream because the cause can be read from the instruction
		nextRec.exc   = dest.exc | src.exc;
	end

	// ==================================================
	// Output register
	// ==================================================

	// The single slot can take a new record when empty or being drained
	assign inReady = ~outValid | outReady;
	assign inFire  = inValid & inReady;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (inFire)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (inFire)
			outData <= nextRec;
	end

	// A held record must not change until the consumer takes it
	holdStable: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> $stable(outData))
		else $error("decoded record changed under back-pressure");

	// A producer that is held off keeps the same word on the input
	inputHeld: assert property (@(posedge clk) disable iff (!arstN)
		inValid && !inReady |=> inValid && $stable(inData))
		else $error("input word dropped or changed while stalled");

	inValidKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(inValid))
		else $error("inValid is unknown");

endmodule

`default_nettype wire

/* srcDecoder.sv */
// Finds both source registers of one instruction and maps them under the current mode
`timescale 1ns/100ps
`default_nettype none

module srcDecoder import starkDecodePkg::*; (
	input wire decodeIn_t inData,
	output srcInfo_t      src
);

	instruction_t ins;
	logic         movSrcBank;
	logic         regForm;
	aregno_t      rawRs1;
	aregno_t      rawRs2;
	aregno_t      mappedRs1;
	aregno_t      mappedRs2;
	logic         exc1;
	logic         exc2;

	assign ins = inData.instr;

	// MOV sub-functions 4 and above read from a banked source
	assign movSrcBank = (ins.opcode == OP_MOV) && (ins[28:26] >= 3'd4);
	// Bit 31 set means the ALU op takes an immediate in place of rs2
	assign regForm    = ins[31];

	// ==================================================
	// First source
	// ==================================================

	always_comb
	begin
		rawRs1 = 7'd0;
		if (isAluOp(ins.opcode) || isLoadOp(ins.opcode) || isBranchOp(ins.opcode)
			|| ins.opcode == OP_CSR || ins.opcode == OP_STORE)
			rawRs1 = {2'b00, ins.rs1};
		else if (ins.opcode == OP_FLT)
			rawRs1 = {2'b01, ins.rs1};
		else if (ins.opcode == OP_MOV)
			// Source bank lives in bits 20 to 19
			rawRs1 = movSrcBank ? {ins[20:19], ins.rs1} : {2'b00, ins.rs1};
	end

	// ==================================================
	// Second source
	// ==================================================

	always_comb
	begin
		rawRs2 = 7'd0;
		if (isAluOp(ins.opcode) && !regForm)
			rawRs2 = {2'b00, ins.rs2};
		else if (ins.opcode == OP_STORE || ins.opcode == OP_CMPSWAP)
			rawRs2 = {2'b00, ins.rs2};
		else if (ins.opcode == OP_FLT)
			rawRs2 = {2'b01, ins.rs2};
	end

	// Sources are read before any mode move takes effect
	regMapper rs1Map (
		.mode     (inData.mode),
		.areg     (rawRs1),
		.bankMove (movSrcBank),
		.mapped   (mappedRs1),
		.exc      (exc1)
	);

	regMapper rs2Map (
		.mode     (inData.mode),
		.areg     (rawRs2),
		.bankMove (1'b0),
		.mapped   (mappedRs2),
		.exc      (exc2)
	);

	always_comb
	begin
		src.rs1 = mappedRs1;
		src.rs2 = mappedRs2;
		src.exc = exc1 | exc2;
	end

endmodule

`default_nettype wire

/* destDecoder.sv */
// Finds the destination register of one instruction, applies mode moves and maps it through banking
`timescale 1ns/100ps
`default_nettype none

module destDecoder import starkDecodePkg::*; (
	input wire decodeIn_t inData,
	output destInfo_t     dest
);

	instruction_t    ins;
	logic [2:0]      movSubFn;
	logic            movDestBank;
	logic            modeMove;
	operating_mode_t effMode;
	aregno_t         rawRd;
	aregno_t         mappedRd;
	logic            mapExc;

	assign ins = inData.instr;

	// MOV sub-function sits in bits 28 to 26
	// Values below 4 write a banked destination
	assign movSubFn    = ins[28:26];
	assign movDestBank = (ins.opcode == OP_MOV) && (movSubFn < 3'd4);

	// ==================================================
	// Destination selection
	// ==================================================

	always_comb
	begin
		rawRd = 7'd0;
		if (isAluOp(ins.opcode) || isLoadOp(ins.opcode) || ins.opcode == OP_CSR)
			rawRd = {2'b00, ins.rd};
		else if (ins.opcode == OP_FLT)
			rawRd = {2'b01, ins.rd};
		else if (ins.opcode == OP_MOV)
		begin
			// Destination bank in bits 18 to 17 selects the register file
			if (movDestBank)
				rawRd = {ins[18:17], ins.rd};
			else
				rawRd = {2'b00, ins.rd};
		end
		else if (isBranchOp(ins.opcode))
		begin
			// Link field 0 means no link and 7 is reserved
			if (ins[8:6] == 3'd0 || ins[8:6] == 3'd7)
				rawRd = 7'd0;
			else
				rawRd = {4'b1000, ins[8:6]};
		end
	end

	// ==================================================
	// Mode move and mapping
	// ==================================================

	// Sub-function 1 is the mode move, which switches mode before the write
	assign modeMove = (ins.opcode == OP_MOV) && (movSubFn == 3'd1);
	assign effMode  = modeMove ? operating_mode_t'(ins[22:21]) : inData.mode;

	regMapper rdMap (
		.mode     (effMode),
		.areg     (rawRd),
		.bankMove (movDestBank),
		.mapped   (mappedRd),
		.exc      (mapExc)
	);

	always_comb
	begin
		dest.rd   = mappedRd;
		dest.rdz  = (mappedRd == 7'd0);
		dest.mode = effMode;
		dest.exc  = mapExc;
	end

endmodule

`default_nettype wire

/* regMapper.sv */
// Maps one architectural register under an operating mode to its banked number and flags bad numbers
`timescale 1ns/100ps
`default_nettype none

module regMapper import starkDecodePkg::*; (
	input wire operating_mode_t mode,
	input wire aregno_t         areg,
	// Set when the number came from a MOV bank field
	input wire logic            bankMove,
	output aregno_t             mapped,
	output logic                exc
);

	// ==================================================
	// Stack pointer banking
	// ==================================================

	// Each mode has its own stack pointer in 120 to 123
	// Register 31 is the stack pointer as seen by the program
	localparam aregno_t SpReg   = 7'd31;
	localparam aregno_t SpBank  = 7'd120;
	// First number past the branch-link registers
	localparam aregno_t FirstBad = 7'd72;

	logic isLinkReg;
	logic userLinkMove;

	always_comb
	begin
		if (areg == SpReg)
			mapped = SpBank + {5'd0, mode};
		else
			mapped = areg;
	end

	// ==================================================
	// Illegal register checks
	// ==================================================

	// Link registers occupy 64 to 71, so the top four bits read 1000
	assign isLinkReg = (areg[6:3] == 4'b1000);

	// User code may not reach the link registers through a bank move
	assign userLinkMove = bankMove && isLinkReg && (mode == MODE_USER);

	// Banked stack pointers and anything above the link file are not
	// reachable by number, only through register 31
	always_comb
	begin
		exc = 1'b0;
		if (areg >= FirstBad)
			exc = 1'b1;
		if (userLinkMove)
			exc = 1'b1;
	end

endmodule

`default_nettype wire

/* starkDecodePkg.sv */
// Shared opcode, register and record types for the decode slice, imported by all RTL and the testbench
`default_nettype none

package starkDecodePkg;

	// ==================================================
	// Opcodes and instruction layout
	// ==================================================

	// Major opcode in instruction bits 5 to 0
	// Codes not listed here carry no register operands
	typedef enum logic [5:0] {
		OP_NOP     = 6'h00,
		OP_ADD     = 6'h04,
		OP_SUBF    = 6'h05,
		OP_CMP     = 6'h06,
		OP_AND     = 6'h08,
		OP_OR      = 6'h09,
		OP_XOR     = 6'h0A,
		OP_MUL     = 6'h0C,
		OP_DIV     = 6'h0D,
		OP_SHIFT   = 6'h0E,
		OP_FLT     = 6'h10,
		OP_CSR     = 6'h11,
		OP_MOV     = 6'h12,
		OP_B0      = 6'h20,
		OP_B1      = 6'h21,
		OP_BCC0    = 6'h22,
		OP_BCC1    = 6'h23,
		OP_LDB     = 6'h28,
		OP_LDBZ    = 6'h29,
		OP_LDW     = 6'h2A,
		OP_LDWZ    = 6'h2B,
		OP_LDT     = 6'h2C,
		OP_LDTZ    = 6'h2D,
		OP_LOAD    = 6'h2E,
		OP_LOADA   = 6'h2F,
		OP_AMO     = 6'h30,
		OP_CMPSWAP = 6'h31,
		OP_STORE   = 6'h32
	} opcode_t;

	// Generic three-register layout
	// MOV reuses rs2 and upper for its bank, mode and sub-function fields
	typedef struct packed {
		logic [10:0] upper;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_t     opcode;
	} instruction_t;

	// Architectural register number
	// 0-31 integer, 32-63 float, 64-71 branch link, 120-123 banked stack pointer
	typedef logic [6:0] aregno_t;

	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} operating_mode_t;

	// ==================================================
	// Records passed between the decode blocks
	// ==================================================

	typedef struct packed {
		instruction_t    instr;
		operating_mode_t mode;
	} decodeIn_t;

	// Destination result with the mode that is in force after a mode move
	typedef struct packed {
		aregno_t         rd;
		logic            rdz;
		operating_mode_t mode;
		logic            exc;
	} destInfo_t;

	typedef struct packed {
		aregno_t rs1;
		aregno_t rs2;
		logic    exc;
	} srcInfo_t;

	typedef struct packed {
		instruction_t    instr;
		operating_mode_t mode;
		aregno_t         rd;
		logic            rdz;
		aregno_t         rs1;
		aregno_t         rs2;
		logic            exc;
	} decoded_t;

	// ==================================================
	// Opcode group helpers
	// ==================================================

	function automatic logic isAluOp(input opcode_t op);
		return op inside {OP_ADD, OP_SUBF, OP_CMP, OP_AND, OP_OR, OP_XOR,
			OP_MUL, OP_DIV, OP_SHIFT};
	endfunction

	function automatic logic isBranchOp(input opcode_t op);
		return op inside {OP_B0, OP_B1, OP_BCC0, OP_BCC1};
	endfunction

	// CMPSWAP counts as a load since it returns the old memory value
	function automatic logic isLoadOp(input opcode_t op);
		return op inside {OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ,
			OP_LOAD, OP_LOADA, OP_AMO, OP_CMPSWAP};
	endfunction

endpackage

`default_nettype wire
